/* rv_decode.f */
+incdir+hw
hw/rv_decode_pkg.sv
hw/decode_if.sv
hw/instr_decoder.sv
hw/illegal_instr_check.sv
hw/operand_select.sv
hw/hazard_bypass.sv
hw/id_pipe_ctrl.sv
hw/id_stage.sv
test/id_stage_assertions.sv
test/tb_id_stage.sv

/* Makefile */
SIM = obj_dir/Vtb_id_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f rv_decode.f --top-module tb_id_stage -Mdir obj_dir

run: compile
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "TESTBENCH FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_id_stage.sv */
/*
 * ID stage testbench
 * Random RV32I stimulus checked by the bound assertions
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module tb_id_stage;
  import rv_decode_pkg::*;

  logic      clk = 1'b0;
  logic      rst, flush, ex_stall, if_bubble;
  logic      ex_writes, mem_writes, id_stall;
  xlen_t     if_pc, rf_rdata1, rf_rdata2, id_pc, id_opa, id_opb;
  instr_t    if_instr, id_instr;
  reg_addr_t rf_src1, rf_src2, ex_dst, mem_dst;
  logic      id_bubble, id_illegal;
  logic      id_userf_opa, id_userf_opb, id_bypex_opa, id_bypex_opb;
  logic      id_bypmem_opa, id_bypmem_opb;

  logic [31:0] seed = 32'h193a;
  int          check_errors = 0;
  int          timeout_errors = 0;
  int          assert_errors;

  id_stage uut (.*);

  always #2 clk = ~clk;

  // Register file model with x0 reading zero
  function automatic xlen_t rf_value(input reg_addr_t a);
    if (a == 5'd0) return 32'd0;
    return {8'hc0 ^ {3'd0, a}, 16'h1234, 3'd0, a};
  endfunction

  assign rf_rdata1 = rf_value(rf_src1);
  assign rf_rdata2 = rf_value(rf_src2);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  // Legal templates with small register numbers plus some raw words
  function automatic instr_t pick_instr();
    logic [31:0] r;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r   = next_rand();
    rd  = {2'd0, r[6:4]};
    rs1 = {2'd0, r[9:7]};
    rs2 = {2'd0, r[12:10]};
    f3  = r[15:13];
    f7  = r[16] ? {1'b0, r[17], 5'd0} : r[23:17];
    case (r[3:0])
      4'd0:  return {r[31:12], rd, 7'b0110111};
      4'd1:  return {r[31:12], rd, 7'b0010111};
      4'd2:  return {r[31:12], rd, 7'b1101111};
      4'd3:  return {r[31:20], rs1, 3'd0, rd, 7'b1100111};
      4'd4:  return {r[31:25], rs2, rs1, f3, rd, 7'b1100011};
      4'd5:  return {r[31:20], rs1, f3, rd, 7'b0000011};
      4'd6:  return {r[31:25], rs2, rs1, f3, rd, 7'b0100011};
      4'd7, 4'd8: return {f7, r[24:20], rs1, f3, rd, 7'b0010011};
      4'd9, 4'd10: return {f7, rs2, rs1, f3, rd, 7'b0110011};
      4'd11: return {r[31:20], rs1, f3, rd, 7'b0001111};
      4'd12: return r[17] ? (r[18] ? 32'h0010_0073 : 32'h0000_0073) : {r[31:7], 7'b1110011};
      default: return r;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      check_errors++;
    end
  endtask

  task automatic wait_bubble(input logic level, input int limit);
    int n;
    n = 0;
    while ((id_bubble !== level) && (n < limit)) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (id_bubble !== level) begin
      $display("Timed out waiting for id_bubble to reach %0d", level);
      timeout_errors++;
    end
  endtask

  initial begin
    logic [31:0] r;
    rst = 1'b1;
    flush = 1'b0;
    ex_stall = 1'b0;
    if_bubble = 1'b1;
    if_pc = `RV_PC_INIT;
    if_instr = `RV_INSTR_NOP;
    ex_dst = '0;
    ex_writes = 1'b0;
    mem_dst = '0;
    mem_writes = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    check_value("id_pc", id_pc, `RV_PC_INIT);
    check_value("id_instr", id_instr, `RV_INSTR_NOP);
    rst = 1'b0;
    if_bubble = 1'b0;
    wait_bubble(1'b0, 20);

    for (int i = 0; i < 3000; i++) begin
      @(posedge clk);
      #1;
      r = next_rand();
      if (!ex_stall) if_pc = if_pc + 32'd4;
      ex_stall   = (r[2:0] == 3'd0);
      flush      = (r[6:3] == 4'd0);
      if_bubble  = (r[9:7] == 3'd0);
      ex_dst     = {2'd0, r[12:10]};
      ex_writes  = r[13];
      mem_dst    = {2'd0, r[16:14]};
      mem_writes = r[17];
      if_instr   = pick_instr();
    end

    @(posedge clk);
    #1;
    ex_stall = 1'b0;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    wait_bubble(1'b1, 20);
    repeat (2) @(posedge clk);

    assert_errors = int'(uut.chk.fail_count);
    $display("Errors: checks %0d, assertions %0d, timeouts %0d",
             check_errors, assert_errors, timeout_errors);
    if ((check_errors == 0) && (assert_errors == 0) && (timeout_errors == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/id_stage_assertions.sv */
/*
 * ID stage checker
 * Concurrent assertions on the top-level ports of id_stage
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module id_stage_assertions (
  input wire logic                     clk,
  input wire logic                     rst,
  input wire logic                     flush,
  input wire logic                     ex_stall,
  input wire logic                     id_stall,
  input wire rv_decode_pkg::xlen_t     if_pc,
  input wire rv_decode_pkg::instr_t    if_instr,
  input wire logic                     if_bubble,
  input wire rv_decode_pkg::xlen_t     id_pc,
  input wire rv_decode_pkg::instr_t    id_instr,
  input wire logic                     id_bubble,
  input wire logic                     id_illegal,
  input wire rv_decode_pkg::reg_addr_t rf_src1,
  input wire rv_decode_pkg::reg_addr_t rf_src2,
  input wire rv_decode_pkg::xlen_t     rf_rdata1,
  input wire rv_decode_pkg::xlen_t     rf_rdata2,
  input wire rv_decode_pkg::reg_addr_t ex_dst,
  input wire logic                     ex_writes,
  input wire rv_decode_pkg::reg_addr_t mem_dst,
  input wire logic                     mem_writes,
  input wire rv_decode_pkg::xlen_t     id_opa,
  input wire rv_decode_pkg::xlen_t     id_opb,
  input wire logic                     id_userf_opa,
  input wire logic                     id_userf_opb,
  input wire logic                     id_bypex_opa,
  input wire logic                     id_bypex_opb,
  input wire logic                     id_bypmem_opa,
  input wire logic                     id_bypmem_opb
);
  import rv_decode_pkg::*;

  int unsigned fail_count = 0;
  logic armed = 1'b0;

  always_ff @(posedge clk) begin
    if (rst) begin
      armed <= 1'b1;
    end
  end

  function automatic logic is_legal(input instr_t i);
    logic [2:0] f3;
    logic [6:0] f7;
    logic ok;
    f3 = i[14:12];
    f7 = i[31:25];
    case (i[6:2])
      `RV_OPC_LUI, `RV_OPC_AUIPC, `RV_OPC_JAL, `RV_OPC_MISC_MEM: ok = 1'b1;
      `RV_OPC_JALR:   ok = (f3 == 3'd0);
      `RV_OPC_BRANCH: ok = (f3 != 3'd2) && (f3 != 3'd3);
      `RV_OPC_LOAD:   ok = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
      `RV_OPC_STORE:  ok = (f3 < 3'd3);
      `RV_OPC_OP_IMM: begin
        if (f3 == 3'd1) ok = (f7 == 7'h00);
        else if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
        else ok = 1'b1;
      end
      `RV_OPC_OP: ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
      `RV_OPC_SYSTEM: ok = (i == 32'h0000_0073) || (i == 32'h0010_0073);
      default: ok = 1'b0;
    endcase
    return ok && (i[1:0] == 2'b11);
  endfunction

  function automatic logic has_dst(input instr_t i);
    logic w;
    case (i[6:2])
      `RV_OPC_LUI, `RV_OPC_AUIPC, `RV_OPC_JAL, `RV_OPC_JALR, `RV_OPC_LOAD,
      `RV_OPC_OP_IMM, `RV_OPC_OP, `RV_OPC_SYSTEM: w = 1'b1;
      default: w = 1'b0;
    endcase
    return w && (i[11:7] != 5'd0);
  endfunction

  function automatic logic reads_rs1(input instr_t i);
    return (i[6:2] == `RV_OPC_JALR) || (i[6:2] == `RV_OPC_LOAD) ||
           (i[6:2] == `RV_OPC_OP_IMM) || (i[6:2] == `RV_OPC_STORE) ||
           (i[6:2] == `RV_OPC_BRANCH) || (i[6:2] == `RV_OPC_OP) ||
           (i[6:2] == `RV_OPC_SYSTEM);
  endfunction

  function automatic logic reads_rs2(input instr_t i);
    return (i[6:2] == `RV_OPC_STORE) || (i[6:2] == `RV_OPC_BRANCH) ||
           (i[6:2] == `RV_OPC_OP);
  endfunction

  // Expected {bypex, bypmem, userf} for one source
  function automatic logic [2:0] want_flags(input reg_addr_t src, input logic used,
                                            input instr_t held, input logic held_bub,
                                            input reg_addr_t exd, input logic exw,
                                            input reg_addr_t md, input logic mw);
    logic ex_hit;
    logic wb_hit;
    ex_hit = !held_bub && has_dst(held) && (src == held[11:7]);
    wb_hit = (src != 5'd0) && ((exw && (src == exd)) || (mw && (src == md)));
    if (!used) return 3'b000;
    if (ex_hit) return 3'b100;
    if (wb_hit) return 3'b010;
    return 3'b001;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reset values
  a_reset: assert property (@(posedge clk) armed && $past(rst) |->
      id_bubble && !id_illegal && !id_userf_opa && !id_userf_opb && !id_bypex_opa &&
      !id_bypex_opb && !id_bypmem_opa && !id_bypmem_opb)
    else begin
      $error("reset state wrong");
      fail_count++;
    end

  // Register file addresses come straight from the fetched word
  a_rf_addr: assert property (@(posedge clk) armed |->
      (rf_src1 == if_instr[19:15]) && (rf_src2 == if_instr[24:20]))
    else begin
      $error("register file addresses wrong");
      fail_count++;
    end

  // Pipeline register load
  a_load: assert property (@(posedge clk) armed && !$past(rst) && !$past(ex_stall) &&
      !$past(flush) |->
      (id_pc == $past(if_pc)) && (id_instr == $past(if_instr)) &&
      (id_bubble == $past(if_bubble)))
    else begin
      $error("ID registers did not load the fetched values");
      fail_count++;
    end

  // Operands
  a_lui: assert property (@(posedge clk) armed && !$past(rst) && !$past(ex_stall) &&
      ($past(if_instr[6:2]) == `RV_OPC_LUI) |->
      (id_opa == 32'd0) && (id_opb == {$past(if_instr[31:12]), 12'd0}))
    else begin
      $error("LUI operands wrong");
      fail_count++;
    end

  a_auipc: assert property (@(posedge clk) armed && !$past(rst) && !$past(ex_stall) &&
      ($past(if_instr[6:2]) == `RV_OPC_AUIPC) |-> id_opa == $past(if_pc))
    else begin
      $error("AUIPC operand A wrong");
      fail_count++;
    end

  a_opimm: assert property (@(posedge clk) armed && !$past(rst) && !$past(ex_stall) &&
      ($past(if_instr[6:2]) == `RV_OPC_OP_IMM) |->
      id_opb == {{20{$past(if_instr[31])}}, $past(if_instr[31:20])})
    else begin
      $error("OP_IMM operand B wrong");
      fail_count++;
    end

  a_regops: assert property (@(posedge clk) armed && !$past(rst) && !$past(ex_stall) &&
      (($past(if_instr[6:2]) == `RV_OPC_OP) || ($past(if_instr[6:2]) == `RV_OPC_BRANCH)) |->
      (id_opa == $past(rf_rdata1)) && (id_opb == $past(rf_rdata2)))
    else begin
      $error("register operands wrong");
      fail_count++;
    end

  // Source flags
  a_flags_a: assert property (@(posedge clk) armed && !$past(rst) && !$past(ex_stall) |->
      {id_bypex_opa, id_bypmem_opa, id_userf_opa} ==
      want_flags($past(if_instr[19:15]), reads_rs1($past(if_instr)), $past(id_instr),
                 $past(id_bubble), $past(ex_dst), $past(ex_writes), $past(mem_dst),
                 $past(mem_writes)))
    else begin
      $error("operand A source flags wrong");
      fail_count++;
    end

  a_flags_b: assert property (@(posedge clk) armed && !$past(rst) && !$past(ex_stall) |->
      {id_bypex_opb, id_bypmem_opb, id_userf_opb} ==
      want_flags($past(if_instr[24:20]), reads_rs2($past(if_instr)), $past(id_instr),
                 $past(id_bubble), $past(ex_dst), $past(ex_writes), $past(mem_dst),
                 $past(mem_writes)))
    else begin
      $error("operand B source flags wrong");
      fail_count++;
    end

  // Illegal flag
  a_illegal: assert property (@(posedge clk) armed && !$past(rst) && !$past(ex_stall) &&
      !$past(flush) |->
      id_illegal == (!$past(if_bubble) && !is_legal($past(if_instr))))
    else begin
      $error("illegal flag wrong");
      fail_count++;
    end

  // Stall, flush and id_stall
  a_hold: assert property (@(posedge clk) armed && !$past(rst) && $past(ex_stall) &&
      !$past(flush) |->
      (id_pc == $past(id_pc)) && (id_instr == $past(id_instr)) &&
      (id_bubble == $past(id_bubble)) && (id_illegal == $past(id_illegal)) &&
      (id_opa == $past(id_opa)) && (id_opb == $past(id_opb)) &&
      ({id_bypex_opa, id_bypmem_opa, id_userf_opa} ==
       $past({id_bypex_opa, id_bypmem_opa, id_userf_opa})) &&
      ({id_bypex_opb, id_bypmem_opb, id_userf_opb} ==
       $past({id_bypex_opb, id_bypmem_opb, id_userf_opb})))
    else begin
      $error("ID outputs moved during stall");
      fail_count++;
    end

  a_flush: assert property (@(posedge clk) armed && !$past(rst) && $past(flush) |->
      id_bubble && !id_illegal)
    else begin
      $error("flush did not insert a bubble");
      fail_count++;
    end

  a_stall_out: assert property (@(posedge clk) armed |->
      id_stall == (ex_stall && !if_bubble && !flush))
    else begin
      $error("id_stall wrong");
      fail_count++;
    end

endmodule

bind id_stage id_stage_assertions chk (.*);

`default_nettype wire

/* hw/id_stage.sv */
/*
 * RV32I instruction decode stage
 * Decodes the fetched word and registers operands and bypass flags
 */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     flush,
  input  logic                     ex_stall,
  output logic                     id_stall,
  // Fetch side
  input  rv_decode_pkg::xlen_t     if_pc,
  input  rv_decode_pkg::instr_t    if_instr,
  input  logic                     if_bubble,
  output rv_decode_pkg::xlen_t     id_pc,
  output rv_decode_pkg::instr_t    id_instr,
  output logic                     id_bubble,
  output logic                     id_illegal,
  // Register file, data returns in the same cycle
  output rv_decode_pkg::reg_addr_t rf_src1,
  output rv_decode_pkg::reg_addr_t rf_src2,
  input  rv_decode_pkg::xlen_t     rf_rdata1,
  input  rv_decode_pkg::xlen_t     rf_rdata2,
  // Later stages
  input  rv_decode_pkg::reg_addr_t ex_dst,
  input  logic                     ex_writes,
  input  rv_decode_pkg::reg_addr_t mem_dst,
  input  logic                     mem_writes,
  // To execute
  output rv_decode_pkg::xlen_t     id_opa,
  output rv_decode_pkg::xlen_t     id_opb,
  output logic                     id_userf_opa,
  output logic                     id_userf_opb,
  output logic                     id_bypex_opa,
  output logic                     id_bypex_opb,
  output logic                     id_bypmem_opa,
  output logic                     id_bypmem_opb
);

  logic advance;
  logic illegal;

  decode_if dec ();

  instr_decoder u_decoder (
    .if_instr (if_instr),
    .dec      (dec.source),
    .rf_src1  (rf_src1),
    .rf_src2  (rf_src2)
  );

  illegal_instr_check u_illegal (
    .dec      (dec.sink),
    .if_instr (if_instr),
    .illegal  (illegal)
  );

  operand_select u_opsel (
    .clk, .rst, .advance,
    .dec      (dec.sink),
    .if_pc, .rf_rdata1, .rf_rdata2, .id_opa, .id_opb
  );

  hazard_bypass u_bypass (
    .clk, .rst, .advance, .id_bubble,
    .dec      (dec.sink),
    .ex_dst, .ex_writes, .mem_dst, .mem_writes,
    .id_userf_opa, .id_userf_opb, .id_bypex_opa, .id_bypex_opb,
    .id_bypmem_opa, .id_bypmem_opb
  );

  id_pipe_ctrl u_pipe (
    .clk, .rst, .flush, .ex_stall, .if_pc, .if_instr, .if_bubble, .illegal,
    .advance, .id_stall, .id_pc, .id_instr, .id_bubble, .id_illegal
  );

endmodule

`default_nettype wire

/* hw/id_pipe_ctrl.sv */
/*
 * ID pipeline control
 * PC, instruction, bubble and illegal registers with stall and flush
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module id_pipe_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  logic                  ex_stall,
  input  rv_decode_pkg::xlen_t  if_pc,
  input  rv_decode_pkg::instr_t if_instr,
  input  logic                  if_bubble,
  input  logic                  illegal,
  output logic                  advance,
  output logic                  id_stall,
  output rv_decode_pkg::xlen_t  id_pc,
  output rv_decode_pkg::instr_t id_instr,
  output logic                  id_bubble,
  output logic                  id_illegal
);

  assign advance = ~ex_stall;

  // Fetch only needs to hold a real instruction, flush wins over stall
  assign id_stall = ex_stall & ~if_bubble & ~flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_pc      <= `RV_PC_INIT;
      id_instr   <= `RV_INSTR_NOP;
      id_bubble  <= 1'b1;
      id_illegal <= 1'b0;
    end else if (flush) begin
      id_bubble  <= 1'b1;
      id_illegal <= 1'b0;
    end else if (advance) begin
      id_pc      <= if_pc;
      id_instr   <= if_instr;
      id_bubble  <= if_bubble;
      id_illegal <= illegal & ~if_bubble;
    end
  end

endmodule

`default_nettype wire

/* hw/hazard_bypass.sv */
/*
 * Hazard and bypass selection
 * Chooses register file, EX bypass or writeback-side bypass per operand
 */
`timescale 1ns/1ps
`default_nettype none

module hazard_bypass (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     advance,
  input  logic                     id_bubble,
  decode_if.sink                   dec,
  input  rv_decode_pkg::reg_addr_t ex_dst,
  input  logic                     ex_writes,
  input  rv_decode_pkg::reg_addr_t mem_dst,
  input  logic                     mem_writes,
  output logic                     id_userf_opa,
  output logic                     id_userf_opb,
  output logic                     id_bypex_opa,
  output logic                     id_bypex_opb,
  output logic                     id_bypmem_opa,
  output logic                     id_bypmem_opb
);
  import rv_decode_pkg::*;

  // Destination of the instruction now held in ID
  reg_addr_t id_dst_q;
  logic      id_wr_q;

  logic [2:0] flags_a;
  logic [2:0] flags_b;

  // Returns {bypex, bypmem, userf} as a one-hot code when used
  function automatic logic [2:0] pick_src(input reg_addr_t src, input logic used);
    logic hit_ex;
    logic hit_wb;
    hit_ex = (src == id_dst_q) && id_wr_q && !id_bubble;
    // EX and writeback-side results both reach the later stage
    hit_wb = (src != '0) && ((ex_writes && (src == ex_dst)) ||
                             (mem_writes && (src == mem_dst)));
    return {used && hit_ex, used && !hit_ex && hit_wb, used && !hit_ex && !hit_wb};
  endfunction

  always_comb begin
    flags_a = pick_src(dec.src1, dec.uses_src1);
    flags_b = pick_src(dec.src2, dec.uses_src2);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_wr_q <= 1'b0;
      {id_bypex_opa, id_bypmem_opa, id_userf_opa} <= 3'b000;
      {id_bypex_opb, id_bypmem_opb, id_userf_opb} <= 3'b000;
    end else if (advance) begin
      id_wr_q <= dec.writes_dst;
      {id_bypex_opa, id_bypmem_opa, id_userf_opa} <= flags_a;
      {id_bypex_opb, id_bypmem_opb, id_userf_opb} <= flags_b;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      id_dst_q <= dec.dst;
    end
  end

endmodule

`default_nettype wire

/* hw/operand_select.sv */
/*
 * Operand select
 * Registers operands A and B for the execute stage
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module operand_select (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 advance,
  decode_if.sink               dec,
  input  rv_decode_pkg::xlen_t if_pc,
  input  rv_decode_pkg::xlen_t rf_rdata1,
  input  rv_decode_pkg::xlen_t rf_rdata2,
  output rv_decode_pkg::xlen_t id_opa,
  output rv_decode_pkg::xlen_t id_opb
);
  import rv_decode_pkg::*;

  xlen_t opa_nxt;
  xlen_t opb_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Operand A: PC, zero or rs1 data
  always_comb begin
    if (dec.opa_is_pc) begin
      opa_nxt = if_pc;
    end else if (dec.opa_is_zero) begin
      opa_nxt = '0;
    end else begin
      opa_nxt = rf_rdata1;
    end
  end

  // Operand B: immediate or rs2 data
  always_comb begin
    if (dec.opb_is_imm) begin
      opb_nxt = dec.imm;
    end else if (dec.opcode == `RV_OPC_SYSTEM) begin
      // CSR immediate forms take the rs1 field as a value
      opb_nxt = {{(`RV_XLEN-`RV_REG_AW){1'b0}}, dec.src1};
    end else begin
      opb_nxt = rf_rdata2;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_opa <= '0;
      id_opb <= '0;
    end else if (advance) begin
      id_opa <= opa_nxt;
      id_opb <= opb_nxt;
    end
  end

endmodule

`default_nettype wire

/* hw/illegal_instr_check.sv */
/*
 * RV32I legality check
 * Flags encodings outside the base integer set
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module illegal_instr_check (
  decode_if.sink                dec,
  input  rv_decode_pkg::instr_t if_instr,
  output logic                  illegal
);
  import rv_decode_pkg::*;

  localparam instr_t ECALL  = 32'h0000_0073;
  localparam instr_t EBREAK = 32'h0010_0073;

  logic ok;

  always_comb begin
    case (dec.opcode)
      `RV_OPC_LUI, `RV_OPC_AUIPC, `RV_OPC_JAL, `RV_OPC_MISC_MEM:
        ok = 1'b1;
      `RV_OPC_JALR:
        ok = (dec.funct3 == 3'd0);
      // funct3 2 and 3 are unused branch codes
      `RV_OPC_BRANCH:
        ok = (dec.funct3 != 3'd2) && (dec.funct3 != 3'd3);
      `RV_OPC_LOAD:
        ok = (dec.funct3 <= 3'd2) || (dec.funct3 == 3'd4) || (dec.funct3 == 3'd5);
      `RV_OPC_STORE:
        ok = (dec.funct3 <= 3'd2);
      `RV_OPC_OP_IMM: begin
        case (dec.funct3)
          // SLLI
          3'd1:    ok = (dec.funct7 == 7'h00);
          // SRLI or SRAI
          3'd5:    ok = (dec.funct7 == 7'h00) || (dec.funct7 == 7'h20);
          default: ok = 1'b1;
        endcase
      end
      // Only SUB and SRA use the alternate funct7
      `RV_OPC_OP:
        ok = (dec.funct7 == 7'h00) ||
             ((dec.funct7 == 7'h20) && ((dec.funct3 == 3'd0) || (dec.funct3 == 3'd5)));
      `RV_OPC_SYSTEM:
        ok = (if_instr == ECALL) || (if_instr == EBREAK);
      default:
        ok = 1'b0;
    endcase
  end

  // Compressed or reserved length encodings are never accepted
  assign illegal = (if_instr[1:0] != 2'b11) || !ok;

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
/*
 * Instruction decoder
 * Splits the fetched word into fields, picks the immediate format
 * and sets the operand source controls
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module instr_decoder (
  input  rv_decode_pkg::instr_t    if_instr,
  decode_if.source                 dec,
  output rv_decode_pkg::reg_addr_t rf_src1,
  output rv_decode_pkg::reg_addr_t rf_src2
);
  import rv_decode_pkg::*;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;
  logic  wr;

  assign dec.opcode = if_instr[6:2];
  assign dec.funct3 = if_instr[14:12];
  assign dec.funct7 = if_instr[31:25];
  assign dec.src1   = if_instr[19:15];
  assign dec.src2   = if_instr[24:20];
  assign dec.dst    = if_instr[11:7];

  // Register file addresses go out straight from the fetched word
  assign rf_src1 = if_instr[19:15];
  assign rf_src2 = if_instr[24:20];

  ////////////////////////////////////////////////////////////////////////////
  // Immediate formats
  assign imm_i = {{(`RV_XLEN-12){if_instr[31]}}, if_instr[31:20]};
  assign imm_s = {{(`RV_XLEN-12){if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
  assign imm_b = {{(`RV_XLEN-12){if_instr[31]}}, if_instr[7], if_instr[30:25],
                  if_instr[11:8], 1'b0};
  assign imm_u = {if_instr[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-20){if_instr[31]}}, if_instr[19:12], if_instr[20],
                  if_instr[30:21], 1'b0};

  always_comb begin
    dec.uses_src1   = 1'b0;
    dec.uses_src2   = 1'b0;
    dec.imm         = '0;
    dec.opa_is_pc   = 1'b0;
    dec.opa_is_zero = 1'b0;
    dec.opb_is_imm  = 1'b0;
    wr              = 1'b0;
    case (if_instr[6:2])
      `RV_OPC_LUI: begin
        wr = 1'b1; dec.imm = imm_u; dec.opa_is_zero = 1'b1; dec.opb_is_imm = 1'b1;
      end
      `RV_OPC_AUIPC: begin
        wr = 1'b1; dec.imm = imm_u; dec.opa_is_pc = 1'b1; dec.opb_is_imm = 1'b1;
      end
      `RV_OPC_JAL: begin
        wr = 1'b1; dec.imm = imm_j; dec.opa_is_pc = 1'b1; dec.opb_is_imm = 1'b1;
      end
      `RV_OPC_JALR, `RV_OPC_LOAD, `RV_OPC_OP_IMM: begin
        wr = 1'b1; dec.uses_src1 = 1'b1; dec.imm = imm_i; dec.opb_is_imm = 1'b1;
      end
      // Store data rides on operand B, offset stays in imm
      `RV_OPC_STORE: begin
        dec.uses_src1 = 1'b1; dec.uses_src2 = 1'b1; dec.imm = imm_s;
      end
      `RV_OPC_BRANCH: begin
        dec.uses_src1 = 1'b1; dec.uses_src2 = 1'b1; dec.imm = imm_b;
      end
      `RV_OPC_OP: begin
        wr = 1'b1; dec.uses_src1 = 1'b1; dec.uses_src2 = 1'b1;
      end
      `RV_OPC_SYSTEM: begin
        wr = 1'b1; dec.uses_src1 = 1'b1; dec.imm = imm_i;
      end
      default: ;
    endcase
  end

  // x0 is never a real destination
  assign dec.writes_dst = wr & (if_instr[11:7] != '0);

endmodule

`default_nettype wire

/* hw/decode_if.sv */
/*
 * Decoded instruction fields
 * Driven by the instruction decoder, read by the ID blocks
 */
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
  import rv_decode_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  reg_addr_t src1;
  reg_addr_t src2;
  reg_addr_t dst;
  logic uses_src1;
  logic uses_src2;
  logic writes_dst;
  xlen_t imm;
  // Operand source controls
  logic opa_is_pc;
  logic opa_is_zero;
  logic opb_is_imm;

  modport source (
    output opcode, funct3, funct7, src1, src2, dst, uses_src1, uses_src2,
           writes_dst, imm, opa_is_pc, opa_is_zero, opb_is_imm
  );

  modport sink (
    input opcode, funct3, funct7, src1, src2, dst, uses_src1, uses_src2,
          writes_dst, imm, opa_is_pc, opa_is_zero, opb_is_imm
  );

endinterface

`default_nettype wire

/* hw/rv_decode_pkg.sv */
/*
 * RV32I decode stage types
 * Plain vector types shared by the decode stage blocks
 */
`default_nettype none

`include "rv_decode_consts.svh"

package rv_decode_pkg;

  // Data and PC values
  typedef logic [`RV_XLEN-1:0] xlen_t;
  typedef logic [31:0] instr_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // Instruction fields
  typedef logic [4:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

endpackage

`default_nettype wire

/* hw/rv_decode_consts.svh */
/*
 * RV32I decode stage constants
 * Widths, major opcode values and reset values
 */
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

`define RV_XLEN 32
`define RV_REG_AW 5
`define RV_PC_INIT 32'h0000_0200

// Major opcodes, instruction bits 6:2
`define RV_OPC_LOAD 5'b00000
`define RV_OPC_MISC_MEM 5'b00011
`define RV_OPC_OP_IMM 5'b00100
`define RV_OPC_AUIPC 5'b00101
`define RV_OPC_STORE 5'b01000
`define RV_OPC_OP 5'b01100
`define RV_OPC_LUI 5'b01101
`define RV_OPC_BRANCH 5'b11000
`define RV_OPC_JALR 5'b11001
`define RV_OPC_JAL 5'b11011
`define RV_OPC_SYSTEM 5'b11100

// addi x0,x0,0
`define RV_INSTR_NOP 32'h0000_0013

`endif
